//--- list.f
+incdir+include
logic/cpuPkg.sv
logic/registerFile.sv
logic/aluUnit.sv
logic/fetchUnit.sv
logic/instQueue.sv
logic/executeUnit.sv
logic/cpuTop.sv
tb/cpuTop_assertions.sv
tb/cpuTb.sv

//--- include/cpuModel.svh
// ~~~~~~~~~~~~~~~~~~~~
// CPU reference model
// Program encoders and an ISA run giving expected stores
// ~~~~~~~~~~~~~~~~~~~~
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

function automatic cpuPkg::wordT encAlu(cpuPkg::aluOpT op, int dst, int a, int b);
    return {4'b0001, 1'b0, 2'b00, op, 4'(dst), 4'(a), 4'(b), 8'h00};
endfunction

function automatic cpuPkg::wordT encAluImm(cpuPkg::aluOpT op, int dst, int a,
                                           int shift, int value);
    return {4'b0001, 1'b1, 2'b00, op, 4'(dst), 4'(a), 4'(shift), 8'(value)};
endfunction

function automatic cpuPkg::wordT encDirect(int dst, int shift, int value, bit isOr);
    return {3'b001, isOr, 4'(dst), 4'(shift), 20'(value)};
endfunction

function automatic cpuPkg::wordT encStore(int base, int src, int offset);
    return {4'b0110, 4'(base), 4'(src), 20'(offset)};
endfunction

function automatic cpuPkg::wordT encBranch(int cond, int base, int offset);
    return {4'b1000, 4'(cond), 4'(base), 20'(offset)};
endfunction

function automatic cpuPkg::wordT encHalt();
    return {6'b000001, cpuPkg::CoreHalt, 20'h0};
endfunction

// Class from the leading opcode bits
function automatic cpuPkg::opClassT instClass(input cpuPkg::wordT w);
    if (w[31])
        return cpuPkg::OpBranch;
    if (w[31:29] == 3'b011)
        return cpuPkg::OpStore;
    if (w[31:29] == 3'b001)
        return cpuPkg::OpDirect;
    if (w[31:28] == 4'b0001)
        return cpuPkg::OpAlu;
    if (w[31:26] == 6'b000001)
        return cpuPkg::OpCore;
    return cpuPkg::OpIllegal;
endfunction

// Condition code 15 never branches
function automatic logic conditionMet(input logic [3:0] cond, input cpuPkg::flagsT f);
    logic lt;
    logic [15:0] outcomes;
    lt = f.negative ^ f.overflow;
    outcomes = {1'b0, f.zero | lt, !f.zero & !lt, lt, !lt,
                !f.carry | f.zero, f.carry & !f.zero, !f.overflow, f.overflow,
                !f.negative, f.negative, !f.carry, f.carry, !f.zero, f.zero, 1'b1};
    return outcomes[cond];
endfunction

function automatic logic [cpuPkg::DataWidth:0] modelAlu(input cpuPkg::aluOpT op,
        input cpuPkg::wordT a, input cpuPkg::wordT b, input logic cin, output logic ovf);
    logic [cpuPkg::DataWidth:0] r;
    logic [4:0] amt;
    longint unsigned ua;
    longint unsigned ub;
    longint sa;
    longint sb;
    longint ci;
    longint sum;
    amt = b[4:0];
    ua = a;
    ub = b;
    sa = $signed(a);
    sb = $signed(b);
    ci = cin;
    sum = 0;
    case (op)
        cpuPkg::AluAddc: begin
            r = 33'(ua + ub + ci);
            sum = sa + sb + ci;
        end
        cpuPkg::AluSubc: begin
            r = 33'(ua - ub - ci);
            sum = sa - sb - ci;
        end
        cpuPkg::AluAnd: r = {1'b0, a & b};
        cpuPkg::AluOr: r = {1'b0, a | b};
        cpuPkg::AluXor: r = {1'b0, a ^ b};
        cpuPkg::AluNot: r = {1'b0, ~a};
        cpuPkg::AluShl: r = 33'(ua << b);
        cpuPkg::AluAsr: r = {1'b0, 32'(sa >>> b)};
        cpuPkg::AluLsr: r = {1'b0, 32'(ua >> b)};
        cpuPkg::AluRor: r = {1'b0, (a >> amt) | (a << (6'd32 - amt))};
        cpuPkg::AluRol: r = {1'b0, (a << amt) | (a >> (6'd32 - amt))};
        cpuPkg::AluAndn: r = {1'b0, a & ~b};
        cpuPkg::AluSub: begin
            r = 33'(ua - ub);
            sum = sa - sb;
        end
        default: r = '0;
    endcase
    // Exact signed result outside the 32-bit range
    ovf = (sum[63:31] != '0) && (sum[63:31] != '1);
    return r;
endfunction

// Registers and flags start at zero
function automatic void runModel(input cpuPkg::wordT prog [64],
                                 output cpuPkg::memWriteT stores [$]);
    cpuPkg::wordT regs [16];
    cpuPkg::instWordT w;
    cpuPkg::flagsT fl;
    cpuPkg::wordT pc;
    cpuPkg::wordT b;
    cpuPkg::wordT imm;
    logic [cpuPkg::DataWidth:0] res;
    logic ovf;
    bit done;
    regs = '{default: '0};
    fl = '0;
    pc = '0;
    done = 1'b0;
    stores = {};
    for (int step = 0; step < 64 && !done && pc < 64; step++) begin
        w = prog[pc[5:0]];
        pc = pc + 1;
        case (instClass(w))
            cpuPkg::OpAlu: begin
                imm = cpuPkg::wordT'(w.alu.value) << {w.alu.termB, 1'b0};
                b = w.alu.immediate ? imm : regs[w.alu.termB];
                res = modelAlu(w.alu.operation, regs[w.alu.termA], b, fl.carry, ovf);
                regs[w.alu.destination] = res[31:0];
                fl = '{carry: res[32], zero: (res == '0), negative: res[31], overflow: ovf};
            end
            cpuPkg::OpDirect: begin
                imm = cpuPkg::wordT'(w.imm.value) << w.imm.fieldY;
                regs[w.imm.fieldX] = w.imm.prefix[0] ? (regs[w.imm.fieldX] | imm) : imm;
            end
            cpuPkg::OpStore: begin
                stores.push_back('{valid: 1'b1,
                                   addr: regs[w.imm.fieldX] + cpuPkg::wordT'(w.imm.value),
                                   data: regs[w.imm.fieldY]});
            end
            cpuPkg::OpBranch: begin
                if (conditionMet(w.imm.fieldX, fl)) begin
                    pc = regs[w.imm.fieldY] + cpuPkg::wordT'($signed(w.imm.value));
                end
            end
            cpuPkg::OpCore: done = ({w.imm.fieldX[1:0], w.imm.fieldY} == cpuPkg::CoreHalt);
            default: ;
        endcase
    end
endfunction

`endif

//--- tb/cpuTb.sv
// ~~~~~~~~~~~~~~~~~~~~
// CPU testbench
// Directed and random programs checked against the ISA model
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module cpuTb;
    localparam int ResetCycles = 8;
    localparam int PostHaltCycles = 16;
    localparam int RandomTests = 10;
    localparam int TestCount = 4 + RandomTests;
    localparam int CycleLimit = TestCount * (1 + ResetCycles + 64 * 8 + PostHaltCycles);

    logic iClk;
    logic reset;
    cpuPkg::fetchReqT fetchReq;
    cpuPkg::wordT instData;
    cpuPkg::memWriteT memWrite;
    logic halt;

    cpuPkg::wordT imem [64];
    cpuPkg::memWriteT expected [$];
    int progLen;
    int seenCount;
    int valueErrors;
    int otherErrors;
    int cycleCount;
    logic [31:0] rngState;
    string testName;

    `include "cpuModel.svh"

    cpuTop DUT (
        .iClk    (iClk),
        .reset   (reset),
        .fetchReq(fetchReq),
        .instData(instData),
        .memWrite(memWrite),
        .halt    (halt)
    );

    always #20 iClk = ~iClk;

    // Instruction memory answering one cycle after the request
    always @(posedge iClk) begin
        if (fetchReq.valid) begin
            instData <= imem[fetchReq.addr[5:0]];
        end
    end

    always @(posedge iClk) begin
        cycleCount++;
        if (cycleCount >= CycleLimit) begin
            $display("timeout: no finish after %0d cycles in %s", cycleCount, testName);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // Each store against the next one the model predicts
    always @(posedge iClk) begin
        if (!reset && memWrite.valid) begin
            if (seenCount >= expected.size()) begin
                otherErrors++;
                $display("%s: unexpected store of %h to %h", testName,
                         memWrite.data, memWrite.addr);
            end else if (memWrite.addr != expected[seenCount].addr
                    || memWrite.data != expected[seenCount].data) begin
                valueErrors++;
                $display("error %s store %0d: expected %h at %h, actual %h at %h",
                         testName, seenCount, expected[seenCount].data,
                         expected[seenCount].addr, memWrite.data, memWrite.addr);
            end
            seenCount++;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] nextRandom();
        rngState = xorshift(rngState);
        return rngState;
    endfunction

    task automatic emit(input cpuPkg::wordT w);
        imem[progLen] = w;
        progLen++;
    endtask

    task automatic startTest(input string name);
        @(posedge iClk);
        reset <= 1'b1;
        testName = name;
        progLen = 0;
        // Unused words halt the core
        for (int i = 0; i < 64; i++) begin
            imem[i] = encHalt();
        end
    endtask

    task automatic finishTest();
        runModel(imem, expected);
        seenCount = 0;
        repeat (ResetCycles) @(posedge iClk);
        reset <= 1'b0;
        while (!halt) begin
            @(posedge iClk);
        end
        repeat (PostHaltCycles) begin
            @(posedge iClk);
            if (!halt) begin
                otherErrors++;
                $display("%s: halt dropped while reset was low", testName);
            end
            if (fetchReq.valid) begin
                otherErrors++;
                $display("%s: fetch issued while halted", testName);
            end
        end
        if (seenCount < expected.size()) begin
            otherErrors++;
            $display("%s: only %0d of %0d expected stores seen", testName,
                     seenCount, expected.size());
        end
    endtask

    task automatic aluTest();
        cpuPkg::aluOpT op;
        startTest("alu register form");
        emit(encDirect(1, 12, 'hABCDE, 0));
        emit(encDirect(2, 0, 'h12345, 0));
        emit(encDirect(2, 12, 'h0F0F0, 1));
        emit(encDirect(3, 0, 0, 0));
        emit(encDirect(5, 0, 5, 0));
        // Borrow out leaves carry set for the add with carry
        emit(encAlu(cpuPkg::AluSub, 4, 2, 1));
        for (int i = 0; i < 15; i++) begin
            if (i != 12 && i != 13) begin
                op = cpuPkg::aluOpT'(i);
                emit(encAlu(op, 4, 1, 2));
                emit(encStore(3, 4, 2 * i));
                emit(encAlu(op, 4, 1, 5));
                emit(encStore(3, 4, 2 * i + 1));
            end
        end
        finishTest();
    endtask

    task automatic immTest();
        startTest("immediate forms");
        emit(encDirect(3, 4, 'h10, 0));
        for (int k = 0; k < 6; k++) begin
            emit(encDirect(1, 3 * k, 'hA5A5A + k, 0));
            emit(encStore(3, 1, 3 * k));
            emit(encDirect(1, k, 'h3C3C3, 1));
            emit(encStore(3, 1, 3 * k + 1));
            emit(encAluImm(cpuPkg::AluXor, 2, 1, k, 'h5A + k));
            emit(encStore(3, 2, 3 * k + 2));
        end
        finishTest();
    endtask

    task automatic branchTest();
        startTest("branch conditions");
        emit(encDirect(0, 0, 0, 0));
        emit(encDirect(3, 8, 2, 0));
        emit(encDirect(5, 0, 5, 0));
        emit(encDirect(6, 0, 6, 0));
        emit(encDirect(8, 12, 'h80000, 0));
        emit(encDirect(9, 0, 1, 0));
        for (int c = 0; c < 16; c++) begin
            // Zero, borrow with negative, overflow, then no flags
            case (c % 4)
                0: emit(encAlu(cpuPkg::AluSub, 7, 5, 5));
                1: emit(encAlu(cpuPkg::AluSub, 7, 5, 6));
                2: emit(encAlu(cpuPkg::AluSub, 7, 8, 9));
                default: emit(encAlu(cpuPkg::AluSub, 7, 6, 5));
            endcase
            emit(encBranch(c, 0, progLen + 2));
            emit(encStore(3, 5, c));
        end
        finishTest();
    endtask

    task automatic haltTest();
        startTest("halt");
        emit(encDirect(3, 0, 'h40, 0));
        emit(encDirect(1, 0, 'h777, 0));
        emit(encStore(3, 1, 0));
        emit(encHalt());
        for (int k = 1; k < 8; k++) begin
            emit(encStore(3, 1, k));
        end
        finishTest();
    endtask

    task automatic randomTest(input int index);
        logic [31:0] r;
        cpuPkg::aluOpT op;
        int kind;
        int dst;
        int target;
        startTest($sformatf("random %0d", index));
        // r0 stays zero as the branch base
        emit(encDirect(0, 0, 0, 0));
        for (int i = 1; i < 16; i++) begin
            r = nextRandom();
            emit(encDirect(i, r[23:20], r[19:0], 0));
        end
        for (int i = 0; i < 40; i++) begin
            r = nextRandom();
            kind = r[31:24] % 10;
            dst = 1 + r[3:0] % 15;
            op = cpuPkg::aluOpT'((r[15:12] % 13 == 12) ? 14 : r[15:12] % 13);
            target = progLen + 2 + r[1:0];
            if (target > 63) begin
                target = 63;
            end
            case (kind)
                0, 1, 2, 3: emit(encAlu(op, dst, r[7:4], r[11:8]));
                4, 5: emit(encAluImm(op, dst, r[7:4], r[11:8], r[23:16]));
                6: emit(encDirect(dst, r[11:8], r[23:4], r[12]));
                7, 8: emit(encStore(r[7:4], r[11:8], r[23:4]));
                default: emit(encBranch(r[19:16], 0, target));
            endcase
        end
        finishTest();
    endtask

    initial begin
        iClk = 1'b0;
        reset = 1'b1;
        instData = '0;
        cycleCount = 0;
        valueErrors = 0;
        otherErrors = 0;
        seenCount = 0;
        progLen = 0;
        rngState = 32'd3162;
        testName = "reset";
        aluTest();
        immTest();
        branchTest();
        haltTest();
        for (int n = 0; n < RandomTests; n++) begin
            randomTest(n);
        end
        $display("errors: %0d wrong values, %0d other failures", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end
endmodule

//--- tb/cpuTop_assertions.sv
// ~~~~~~~~~~~~~~~~~~~~
// CPU assertions
// Credit, queue and halt rules bound into the top level
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module cpuTopAssertions #(
    parameter int QueueDepth = 4
) (
    input logic                        iClk,
    input logic                        reset,
    input logic [$clog2(QueueDepth):0] credit,
    input logic                        push,
    input logic [$clog2(QueueDepth):0] count,
    input logic                        halt
);
    creditBound: assert property (@(posedge iClk) disable iff (reset)
        credit <= QueueDepth)
        else $error("credit above queue depth");

    // Credits should make a full queue unreachable at push time
    pushNotFull: assert property (@(posedge iClk) disable iff (reset)
        push |-> count < QueueDepth)
        else $error("push into a full queue");

    haltSticky: assert property (@(posedge iClk) disable iff (reset)
        $fell(halt) |-> $past(reset))
        else $error("halt fell without reset");
endmodule

bind cpuTop cpuTopAssertions #(.QueueDepth(QueueDepth)) checks (
    .iClk  (iClk),
    .reset (reset),
    .credit(fetch.credit),
    .push  (push),
    .count (queue.count),
    .halt  (halt)
);

//--- logic/cpuTop.sv
// ~~~~~~~~~~~~~~~~~~~~
// CPU top
// Fetch, queue and execute joined by credits
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module cpuTop #(
    parameter int QueueDepth = 4
) (
    input  logic             iClk,
    input  logic             reset,
    output cpuPkg::fetchReqT fetchReq,
    input  cpuPkg::wordT     instData,
    output cpuPkg::memWriteT memWrite,
    output logic             halt
);
    cpuPkg::queueEntryT pushEntry;
    cpuPkg::queueEntryT head;
    cpuPkg::redirectT redirect;
    logic push;
    logic creditReturn;
    logic pop;
    logic notEmpty;

    fetchUnit #(.QueueDepth(QueueDepth)) fetch (
        .iClk        (iClk),
        .reset       (reset),
        .fetchReq    (fetchReq),
        .instData    (instData),
        .push        (push),
        .pushEntry   (pushEntry),
        .creditReturn(creditReturn),
        .redirect    (redirect),
        .halt        (halt)
    );

    instQueue #(.QueueDepth(QueueDepth)) queue (
        .iClk        (iClk),
        .reset       (reset),
        .push        (push),
        .pushEntry   (pushEntry),
        .pop         (pop),
        .head        (head),
        .notEmpty    (notEmpty),
        .creditReturn(creditReturn),
        .flush       (redirect.valid)
    );

    executeUnit execute (
        .iClk    (iClk),
        .reset   (reset),
        .head    (head),
        .notEmpty(notEmpty),
        .pop     (pop),
        .redirect(redirect),
        .memWrite(memWrite),
        .halt    (halt)
    );
endmodule

//--- logic/executeUnit.sv
// ~~~~~~~~~~~~~~~~~~~~
// Execute unit
// Runs the queue head, updates flags, branches, stores, halts
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module executeUnit (
    input  logic               iClk,
    input  logic               reset,
    input  cpuPkg::queueEntryT head,
    input  logic               notEmpty,
    output logic               pop,
    output cpuPkg::redirectT   redirect,
    output cpuPkg::memWriteT   memWrite,
    output logic               halt
);
    cpuPkg::instWordT word;
    cpuPkg::opClassT opClass;
    cpuPkg::flagsT flags;
    cpuPkg::aluOpT aluOp;
    cpuPkg::regIndexT readAddrA;
    cpuPkg::regIndexT readAddrB;
    cpuPkg::regIndexT writeAddr;
    cpuPkg::wordT readDataA;
    cpuPkg::wordT readDataB;
    cpuPkg::wordT immOperand;
    cpuPkg::wordT termB;
    cpuPkg::wordT writeData;
    logic [cpuPkg::DataWidth:0] aluResult;
    logic overflow;
    logic isDirect;
    logic writeEnable;
    logic taken;

    assign word = head.inst;
    assign opClass = cpuPkg::decodeClass(word);
    assign isDirect = (opClass == cpuPkg::OpDirect);

    // Redirect cycle keeps wrong-path entries from executing
    assign pop = notEmpty && !halt && !redirect.valid;

    always_comb begin
        readAddrA = word.alu.termA;
        readAddrB = word.alu.termB;
        case (opClass)
            cpuPkg::OpBranch: readAddrA = word.imm.fieldY;
            cpuPkg::OpStore: begin
                readAddrA = word.imm.fieldX;
                readAddrB = word.imm.fieldY;
            end
            cpuPkg::OpDirect: readAddrA = word.imm.fieldX;
            default: ;
        endcase
    end

    // ALU immediates shift by twice the field
    assign immOperand = isDirect
        ? cpuPkg::wordT'(word.imm.value) << word.imm.fieldY
        : cpuPkg::wordT'(word.alu.value) << {word.alu.termB, 1'b0};
    assign termB = (isDirect || word.alu.immediate) ? immOperand : readDataB;
    assign aluOp = (opClass == cpuPkg::OpAlu) ? word.alu.operation : cpuPkg::AluOr;

    assign writeAddr = isDirect ? word.imm.fieldX : word.alu.destination;
    assign writeData = (isDirect && !word.imm.prefix[0])
        ? immOperand : aluResult[cpuPkg::DataWidth-1:0];
    assign writeEnable = pop && (isDirect || opClass == cpuPkg::OpAlu);
    assign taken = cpuPkg::branchTaken(word.imm.fieldX, flags);

    registerFile regs (
        .iClk       (iClk),
        .readAddrA  (readAddrA),
        .readAddrB  (readAddrB),
        .readDataA  (readDataA),
        .readDataB  (readDataB),
        .writeEnable(writeEnable),
        .writeAddr  (writeAddr),
        .writeData  (writeData)
    );

    aluUnit alu (
        .operation(aluOp),
        .termA    (readDataA),
        .termB    (termB),
        .carryIn  (flags.carry),
        .result   (aluResult),
        .overflow (overflow)
    );

    always_ff @(posedge iClk) begin
        if (reset) begin
            flags <= '0;
            redirect <= '0;
            memWrite <= '0;
            halt <= 1'b0;
        end else begin
            redirect.valid <= pop && (opClass == cpuPkg::OpBranch) && taken;
            redirect.target <= readDataA + cpuPkg::addrT'($signed(word.imm.value));
            memWrite.valid <= pop && (opClass == cpuPkg::OpStore);
            memWrite.addr <= readDataA + cpuPkg::addrT'(word.imm.value);
            memWrite.data <= readDataB;
            if (pop && opClass == cpuPkg::OpAlu) begin
                flags <= '{carry: aluResult[cpuPkg::DataWidth],
                           zero: (aluResult == '0),
                           negative: aluResult[cpuPkg::DataWidth-1],
                           overflow: overflow};
            end
            // Sticky until reset
            if (pop && opClass == cpuPkg::OpCore
                    && {word.imm.fieldX[1:0], word.imm.fieldY} == cpuPkg::CoreHalt) begin
                halt <= 1'b1;
            end
        end
    end
endmodule

//--- logic/instQueue.sv
// ~~~~~~~~~~~~~~~~~~~~
// Instruction queue
// Circular FIFO that hands back a credit per pop
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module instQueue #(
    parameter int QueueDepth = 4
) (
    input  logic               iClk,
    input  logic               reset,
    input  logic               push,
    input  cpuPkg::queueEntryT pushEntry,
    input  logic               pop,
    output cpuPkg::queueEntryT head,
    output logic               notEmpty,
    output logic               creditReturn,
    input  logic               flush
);
    localparam int PtrWidth = $clog2(QueueDepth);
    localparam int CountWidth = PtrWidth + 1;

    cpuPkg::queueEntryT entries [QueueDepth];
    logic [PtrWidth-1:0] readPtr;
    logic [PtrWidth-1:0] writePtr;
    logic [CountWidth-1:0] count;
    logic doPush;
    logic doPop;

    assign doPush = push && !flush;
    assign doPop = pop && notEmpty;
    assign head = entries[readPtr];
    assign notEmpty = (count != '0);
    assign creditReturn = doPop;

    always_ff @(posedge iClk) begin
        if (reset || flush) begin
            readPtr <= '0;
            writePtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                writePtr <= writePtr + 1'b1;
            end
            if (doPop) begin
                readPtr <= readPtr + 1'b1;
            end
            count <= count + CountWidth'(doPush) - CountWidth'(doPop);
        end
    end

    always_ff @(posedge iClk) begin
        if (doPush) begin
            entries[writePtr] <= pushEntry;
        end
    end
endmodule

//--- logic/fetchUnit.sv
// ~~~~~~~~~~~~~~~~~~~~
// Fetch unit
// Issues fetches under credit and pushes returned words
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module fetchUnit #(
    parameter int QueueDepth = 4
) (
    input  logic               iClk,
    input  logic               reset,
    output cpuPkg::fetchReqT   fetchReq,
    input  cpuPkg::wordT       instData,
    output logic               push,
    output cpuPkg::queueEntryT pushEntry,
    input  logic               creditReturn,
    input  cpuPkg::redirectT   redirect,
    input  logic               halt
);
    localparam int CreditWidth = $clog2(QueueDepth) + 1;

    logic [CreditWidth-1:0] credit;
    cpuPkg::addrT pc;
    cpuPkg::addrT pendingAddr;
    logic pending;
    logic issue;

    // Hold off one cycle while the target loads
    assign issue = (credit != '0) && !halt && !redirect.valid;

    // Memory answers one cycle after the request
    assign push = pending && !redirect.valid;
    assign pushEntry = '{inst: instData, addr: pendingAddr};

    always_ff @(posedge iClk) begin
        if (reset) begin
            pc <= '0;
            credit <= CreditWidth'(QueueDepth);
            fetchReq <= '0;
            pending <= 1'b0;
        end else begin
            fetchReq.valid <= issue;
            // Stale fetch from before a redirect is not wanted
            pending <= fetchReq.valid && !redirect.valid;
            if (redirect.valid) begin
                pc <= redirect.target;
                credit <= CreditWidth'(QueueDepth);
            end else begin
                credit <= credit + CreditWidth'(creditReturn) - CreditWidth'(issue);
                if (issue) begin
                    fetchReq.addr <= pc;
                    pc <= pc + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge iClk) begin
        pendingAddr <= fetchReq.addr;
    end
endmodule

//--- logic/aluUnit.sv
// ~~~~~~~~~~~~~~~~~~~~
// ALU
// 33-bit result with carry out and signed overflow
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module aluUnit (
    input  cpuPkg::aluOpT               operation,
    input  cpuPkg::wordT                termA,
    input  cpuPkg::wordT                termB,
    input  logic                        carryIn,
    output logic [cpuPkg::DataWidth:0]  result,
    output logic                        overflow
);
    localparam int Width = cpuPkg::DataWidth;
    localparam int Msb = Width - 1;

    logic [2*Width-1:0] rotRight;
    logic [2*Width-1:0] rotLeft;
    logic [$clog2(Width)-1:0] rotAmount;

    // Rotates come out of a doubled word
    assign rotAmount = termB[$clog2(Width)-1:0];
    assign rotRight = {termA, termA} >> rotAmount;
    assign rotLeft = {termA, termA} << rotAmount;

    always_comb begin
        case (operation)
            cpuPkg::AluAddc: result = {1'b0, termA} + {1'b0, termB} + carryIn;
            cpuPkg::AluSubc: result = {1'b0, termA} - ({1'b0, termB} + carryIn);
            cpuPkg::AluAnd: result = {1'b0, termA & termB};
            cpuPkg::AluOr: result = {1'b0, termA | termB};
            cpuPkg::AluXor: result = {1'b0, termA ^ termB};
            cpuPkg::AluNot: result = {1'b0, ~termA};
            cpuPkg::AluShl: result = {1'b0, termA} << termB;
            cpuPkg::AluAsr: result = {1'b0, $signed(termA) >>> termB};
            cpuPkg::AluLsr: result = {1'b0, termA >> termB};
            cpuPkg::AluRor: result = {1'b0, rotRight[Width-1:0]};
            cpuPkg::AluRol: result = {1'b0, rotLeft[2*Width-1:Width]};
            cpuPkg::AluAndn: result = {1'b0, termA & ~termB};
            cpuPkg::AluSub: result = {1'b0, termA} - {1'b0, termB};
            default: result = '0;
        endcase
        case (operation)
            cpuPkg::AluAddc: overflow = (termA[Msb] == termB[Msb]) && (result[Msb] != termA[Msb]);
            cpuPkg::AluSubc,
            cpuPkg::AluSub: overflow = (termA[Msb] != termB[Msb]) && (result[Msb] != termA[Msb]);
            default: overflow = 1'b0;
        endcase
    end
endmodule

//--- logic/registerFile.sv
// ~~~~~~~~~~~~~~~~~~~~
// Register file
// Sixteen words, two async reads, one write
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module registerFile (
    input  logic             iClk,
    input  cpuPkg::regIndexT readAddrA,
    input  cpuPkg::regIndexT readAddrB,
    output cpuPkg::wordT     readDataA,
    output cpuPkg::wordT     readDataB,
    input  logic             writeEnable,
    input  cpuPkg::regIndexT writeAddr,
    input  cpuPkg::wordT     writeData
);
    cpuPkg::wordT regs [2**cpuPkg::RegIndexWidth];

    assign readDataA = regs[readAddrA];
    assign readDataB = regs[readAddrB];

    always_ff @(posedge iClk) begin
        if (writeEnable) begin
            regs[writeAddr] <= writeData;
        end
    end
endmodule

//--- logic/cpuPkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// CPU package
// Widths, opcodes, instruction word views and bus structs
// ~~~~~~~~~~~~~~~~~~~~
package cpuPkg;
    localparam int DataWidth = 32;
    localparam int AddrWidth = 32;
    localparam int RegIndexWidth = 4;
    localparam logic [5:0] CoreHalt = 6'd2;

    typedef logic [DataWidth-1:0] wordT;
    typedef logic [AddrWidth-1:0] addrT;
    typedef logic [RegIndexWidth-1:0] regIndexT;

    typedef enum logic [2:0] {
        OpBranch, OpStore, OpDirect, OpAlu, OpCore, OpIllegal
    } opClassT;

    typedef enum logic [4:0] {
        AluAddc = 5'd0, AluSubc = 5'd1, AluAnd = 5'd2, AluOr = 5'd3,
        AluXor = 5'd4, AluNot = 5'd5, AluShl = 5'd6, AluAsr = 5'd7,
        AluLsr = 5'd8, AluRor = 5'd9, AluRol = 5'd10, AluAndn = 5'd11,
        AluSub = 5'd14
    } aluOpT;

    typedef struct packed {
        logic [3:0] prefix;
        logic       immediate;
        logic [1:0] spare;
        aluOpT      operation;
        regIndexT   destination;
        regIndexT   termA;
        regIndexT   termB;
        logic [7:0] value;
    } aluViewT;

    // X and Y mean condition/base, base/source or destination/shift by class
    typedef struct packed {
        logic [3:0]  prefix;
        regIndexT    fieldX;
        regIndexT    fieldY;
        logic [19:0] value;
    } immViewT;

    typedef union packed {
        aluViewT alu;
        immViewT imm;
    } instWordT;

    typedef struct packed {
        logic carry, zero, negative, overflow;
    } flagsT;

    typedef struct packed {
        logic valid;
        addrT addr;
    } fetchReqT;

    typedef struct packed {
        instWordT inst;
        addrT     addr;
    } queueEntryT;

    typedef struct packed {
        logic valid;
        addrT target;
    } redirectT;

    typedef struct packed {
        logic valid;
        addrT addr;
        wordT data;
    } memWriteT;

    function automatic opClassT decodeClass(instWordT word);
        casez ({word.imm.prefix, word.imm.fieldX[3:2]})
            6'b1?????: return OpBranch;
            6'b011???: return OpStore;
            6'b001???: return OpDirect;
            6'b0001??: return OpAlu;
            6'b000001: return OpCore;
            default: return OpIllegal;
        endcase
    endfunction

    function automatic logic branchTaken(regIndexT cond, flagsT f);
        case (cond)
            4'd0: return 1'b1;
            4'd1: return f.zero;
            4'd2: return !f.zero;
            4'd3: return f.carry;
            4'd4: return !f.carry;
            4'd5: return f.negative;
            4'd6: return !f.negative;
            4'd7: return f.overflow;
            4'd8: return !f.overflow;
            4'd9: return f.carry && !f.zero;
            4'd10: return !f.carry || f.zero;
            4'd11: return f.negative == f.overflow;
            4'd12: return f.negative != f.overflow;
            4'd13: return !f.zero && (f.negative == f.overflow);
            4'd14: return f.zero || (f.negative != f.overflow);
            default: return 1'b0;
        endcase
    endfunction
endpackage
